//--- src/keyb_defines.svh
`ifndef KEYB_DEFINES_SVH
`define KEYB_DEFINES_SVH

// ----------------------------------------
// Keymap RAM
// ----------------------------------------

// 3 modifier bits, extended flag, scancode and entry number
`define KEYMAP_ADDR_W 14

// ----------------------------------------
// Key event buffer and PS/2 receiver
// ----------------------------------------

`define SCAN_FIFO_DEPTH 4

// System clocks without a PS/2 clock edge before a frame is dropped
`define PS2_IDLE_CYCLES 2000

`endif

//--- src/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    typedef logic [7:0] scan_t;

    // Released flag, extended flag, scancode
    typedef logic [9:0] key_event_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } ps2_rx_state_t;

    // Prefix bytes folded into the following key event
    localparam scan_t SCAN_EXT = 8'hE0;
    localparam scan_t SCAN_REL = 8'hF0;

endpackage

`default_nettype wire

//--- src/speccy_pkg.sv
`default_nettype none

`include "keyb_defines.svh"

package speccy_pkg;

    // Half-row number, 0 to 7
    typedef logic [2:0] row_idx_t;

    // Column mask, keys pressed are 0 in the matrix
    typedef logic [4:0] col_t;

    typedef logic [`KEYMAP_ADDR_W-1:0] keymap_addr_t;
    typedef logic [7:0] keymap_data_t;

    typedef enum logic [3:0] {
        CLEAN,
        IDLE,
        FETCH0,
        FETCH1,
        FETCH2,
        FETCH3,
        APPLY1,
        APPLY2,
        APPLY3,
        APB_ACCESS
    } xlate_state_t;

endpackage

`default_nettype wire

//--- src/ps2_scan_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "keyb_defines.svh"

module ps2_scan_rx
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       ev_valid,
    output key_event_t ev_data,
    output logic       frame_error
);

    localparam int IDLE_W = $clog2(`PS2_IDLE_CYCLES);

    logic [2:0]        clk_sync;
    logic [1:0]        data_sync;
    logic              clk_fall;
    logic              bit_in;
    ps2_rx_state_t     state;
    logic [2:0]        bit_cnt;
    logic [IDLE_W-1:0] idle_cnt;
    scan_t             shift_q;
    logic              parity_q;
    logic              ext_flag;
    logic              rel_flag;

    // ----------------------------------------
    // Line synchronizers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        clk_sync  <= {clk_sync[1:0], ps2_clk};
        data_sync <= {data_sync[0], ps2_data};
    end

    assign clk_fall = clk_sync[2] & ~clk_sync[1];
    assign bit_in   = data_sync[1];

    // ----------------------------------------
    // Frame FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= RX_IDLE;
            bit_cnt     <= '0;
            idle_cnt    <= '0;
            ext_flag    <= 1'b0;
            rel_flag    <= 1'b0;
            ev_valid    <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            ev_valid    <= 1'b0;
            frame_error <= 1'b0;

            if (clk_fall || state == RX_IDLE) begin
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end

            // Keyboard stopped mid frame
            if (!clk_fall && state != RX_IDLE && idle_cnt == IDLE_W'(`PS2_IDLE_CYCLES - 1)) begin
                state <= RX_IDLE;
            end else if (clk_fall) begin
                case (state)
                    RX_IDLE: begin
                        if (!bit_in) begin
                            state   <= RX_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    RX_DATA: begin
                        shift_q <= {bit_in, shift_q[7:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_PARITY;
                        end
                    end
                    RX_PARITY: begin
                        parity_q <= bit_in;
                        state    <= RX_STOP;
                    end
                    RX_STOP: begin
                        state <= RX_IDLE;
                        // Odd parity over data and parity bit
                        if (!bit_in || !(^{shift_q, parity_q})) begin
                            frame_error <= 1'b1;
                        end else if (shift_q == SCAN_EXT) begin
                            ext_flag <= 1'b1;
                        end else if (shift_q == SCAN_REL) begin
                            rel_flag <= 1'b1;
                        end else begin
                            ev_valid <= 1'b1;
                            ev_data  <= {rel_flag, ext_flag, shift_q};
                            ext_flag <= 1'b0;
                            rel_flag <= 1'b0;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/scan_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "keyb_defines.svh"

module scan_fifo
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  key_event_t push_data,
    input  logic       pop,
    output logic       q_valid,
    output key_event_t q_data,
    output logic       overflow
);

    localparam int PTR_W = $clog2(`SCAN_FIFO_DEPTH);

    key_event_t       mem [`SCAN_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == (PTR_W + 1)'(`SCAN_FIFO_DEPTH));
    assign q_valid = (count != '0);
    assign q_data  = mem[rd_ptr];
    assign do_push = push && !full;
    assign do_pop  = pop && q_valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at the last entry
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= push && full;
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`SCAN_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`SCAN_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/keymap_translator.sv
`timescale 1ns/10ps
`default_nettype none

`include "keyb_defines.svh"

module keymap_translator
    import ps2_pkg::*;
    import speccy_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         q_valid,
    input  key_event_t   q_data,
    output logic         q_ready,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  keymap_addr_t paddr,
    input  keymap_data_t pwdata,
    output keymap_data_t prdata,
    output logic         pready,
    input  logic [7:0]   sp_row,
    output col_t         sp_col,
    output logic         master_reset,
    output logic         user_reset,
    output logic         user_nmi,
    output logic         joy_up,
    output logic         joy_down,
    output logic         joy_left,
    output logic         joy_right,
    output logic         joy_fire,
    output logic [4:0]   user_toggles
);

    xlate_state_t state;
    keymap_data_t keymap [2**`KEYMAP_ADDR_W];
    keymap_addr_t ram_addr;
    keymap_data_t ram_q;
    logic [1:0]   entry_sel;
    key_event_t   ev_q;
    row_idx_t     key1_row;
    col_t         key1_col;
    row_idx_t     key2_row;
    col_t         key2_col;
    keymap_data_t ctrl_mask;
    keymap_data_t mod_mask;
    keymap_data_t ctrl_q;
    keymap_data_t mod_q;
    logic [2:0]   modifiers;
    col_t         matrix [8];

    // Press pulls matrix bits low, release lets them go high
    function automatic col_t update_col(col_t cur, col_t mask, logic rel);
        return rel ? (cur | mask) : (cur & ~mask);
    endfunction

    // Output bits follow the opposite sense
    function automatic keymap_data_t update_bits(keymap_data_t cur, keymap_data_t mask,
                                                 logic rel);
        return rel ? (cur & ~mask) : (cur | mask);
    endfunction

    // ----------------------------------------
    // Control FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CLEAN;
        end else begin
            case (state)
                CLEAN: state <= IDLE;
                IDLE: begin
                    // Key events go ahead of the CPU
                    if (q_valid) begin
                        state <= FETCH0;
                    end else if (psel && penable) begin
                        state <= APB_ACCESS;
                    end
                end
                FETCH0:     state <= FETCH1;
                FETCH1:     state <= FETCH2;
                FETCH2:     state <= FETCH3;
                FETCH3:     state <= APPLY1;
                APPLY1:     state <= APPLY2;
                APPLY2:     state <= APPLY3;
                APPLY3:     state <= IDLE;
                APB_ACCESS: state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    assign q_ready = (state == IDLE);
    assign pready  = (state == APB_ACCESS);

    always_ff @(posedge clk) begin
        if (q_valid && q_ready) begin
            ev_q <= q_data;
        end
    end

    // ----------------------------------------
    // Keymap RAM, one port shared by lookup and APB
    // ----------------------------------------
    always_comb begin
        case (state)
            FETCH1:  entry_sel = 2'd1;
            FETCH2:  entry_sel = 2'd2;
            FETCH3:  entry_sel = 2'd3;
            default: entry_sel = 2'd0;
        endcase
        if (state inside {FETCH0, FETCH1, FETCH2, FETCH3}) begin
            ram_addr = {modifiers, ev_q[8], ev_q[7:0], entry_sel};
        end else begin
            ram_addr = paddr;
        end
    end

    always_ff @(posedge clk) begin
        if (state == APB_ACCESS && pwrite) begin
            keymap[paddr] <= pwdata;
        end
        ram_q <= keymap[ram_addr];
    end

    // Loaded while IDLE accepts the access
    assign prdata = ram_q;

    // Read data trails the fetch address by one cycle
    always_ff @(posedge clk) begin
        case (state)
            FETCH1:  {key1_row, key1_col} <= ram_q;
            FETCH2:  {key2_row, key2_col} <= ram_q;
            FETCH3:  ctrl_mask <= ram_q;
            APPLY1:  mod_mask <= ram_q;
            default: ;
        endcase
    end

    // ----------------------------------------
    // Matrix and outputs
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst || state == CLEAN) begin
            for (int i = 0; i < 8; i++) begin
                matrix[i] <= '1;
            end
        end else if (state == APPLY1) begin
            matrix[key1_row] <= update_col(matrix[key1_row], key1_col, ev_q[9]);
        end else if (state == APPLY2) begin
            matrix[key2_row] <= update_col(matrix[key2_row], key2_col, ev_q[9]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state == CLEAN) begin
            ctrl_q <= '0;
            mod_q  <= '0;
        end else if (state == APPLY3) begin
            ctrl_q <= update_bits(ctrl_q, ctrl_mask, ev_q[9]);
            mod_q  <= update_bits(mod_q, mod_mask, ev_q[9]);
        end
    end

    assign {master_reset, user_reset, user_nmi} = ctrl_q[7:5];
    assign {joy_up, joy_down, joy_left, joy_right, joy_fire} = ctrl_q[4:0];
    assign modifiers    = mod_q[7:5];
    assign user_toggles = mod_q[4:0];

    // Selected half-rows are ANDed onto the data bus
    always_comb begin
        sp_col = '1;
        for (int i = 0; i < 8; i++) begin
            if (!sp_row[i]) begin
                sp_col = sp_col & matrix[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/speccy_keyboard.sv
`timescale 1ns/10ps
`default_nettype none

module speccy_keyboard
    import ps2_pkg::*;
    import speccy_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         ps2_clk,
    input  logic         ps2_data,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  keymap_addr_t paddr,
    input  keymap_data_t pwdata,
    output keymap_data_t prdata,
    output logic         pready,
    input  logic [7:0]   sp_row,
    output col_t         sp_col,
    output logic         master_reset,
    output logic         user_reset,
    output logic         user_nmi,
    output logic         joy_up,
    output logic         joy_down,
    output logic         joy_left,
    output logic         joy_right,
    output logic         joy_fire,
    output logic [4:0]   user_toggles,
    output logic         frame_error,
    output logic         overflow
);

    logic       ev_valid;
    key_event_t ev_data;
    logic       q_valid;
    key_event_t q_data;
    logic       q_ready;

    ps2_scan_rx ps2_scan_rx_i (
        .clk         (clk),
        .rst         (rst),
        .ps2_clk     (ps2_clk),
        .ps2_data    (ps2_data),
        .ev_valid    (ev_valid),
        .ev_data     (ev_data),
        .frame_error (frame_error)
    );

    scan_fifo scan_fifo_i (
        .clk       (clk),
        .rst       (rst),
        .push      (ev_valid),
        .push_data (ev_data),
        .pop       (q_ready),
        .q_valid   (q_valid),
        .q_data    (q_data),
        .overflow  (overflow)
    );

    keymap_translator keymap_translator_i (
        .clk          (clk),
        .rst          (rst),
        .q_valid      (q_valid),
        .q_data       (q_data),
        .q_ready      (q_ready),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .sp_row       (sp_row),
        .sp_col       (sp_col),
        .master_reset (master_reset),
        .user_reset   (user_reset),
        .user_nmi     (user_nmi),
        .joy_up       (joy_up),
        .joy_down     (joy_down),
        .joy_left     (joy_left),
        .joy_right    (joy_right),
        .joy_fire     (joy_fire),
        .user_toggles (user_toggles)
    );

endmodule

`default_nettype wire

//--- verif/speccy_keyboard_assert.sv
`timescale 1ns/10ps
`default_nettype none

module speccy_keyboard_assert (
    input logic       clk,
    input logic       rst,
    input logic       psel,
    input logic       penable,
    input logic       pready,
    input logic       ev_valid,
    input logic       frame_error,
    input logic       overflow,
    input logic [7:0] ctrl_bits,
    input logic [4:0] user_toggles
);

    int fail_count = 0;

    // pready only inside an APB access phase
    pready_in_access: assert property (@(posedge clk) disable iff (rst)
        pready |-> (psel && penable))
    else begin
        fail_count++;
        $error("pready high outside an APB access phase");
    end

    // Outputs and pulses cleared one cycle into reset
    outputs_after_reset: assert property (@(posedge clk)
        rst |=> (ctrl_bits == '0 && user_toggles == '0 && !pready && !ev_valid
                 && !frame_error && !overflow))
    else begin
        fail_count++;
        $error("Outputs not cleared by reset");
    end

    event_or_error: assert property (@(posedge clk) disable iff (rst)
        !(ev_valid && frame_error))
    else begin
        fail_count++;
        $error("Key event and frame error in the same cycle");
    end

endmodule

bind speccy_keyboard speccy_keyboard_assert speccy_keyboard_assert_i (
    .clk          (clk),
    .rst          (rst),
    .psel         (psel),
    .penable      (penable),
    .pready       (pready),
    .ev_valid     (ev_valid),
    .frame_error  (frame_error),
    .overflow     (overflow),
    .ctrl_bits    ({master_reset, user_reset, user_nmi,
                    joy_up, joy_down, joy_left, joy_right, joy_fire}),
    .user_toggles (user_toggles)
);

`default_nettype wire

//--- verif/tb_speccy_keyboard.sv
`timescale 1ns/10ps
`default_nettype none

`include "keyb_defines.svh"

module tb_speccy_keyboard
    import ps2_pkg::*;
    import speccy_pkg::*;
();

    // 30 PS/2 bytes at about 460 cycles, plus APB and checks, about 14500
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int HALF_BIT = 20;

    logic         clk;
    logic         rst;
    logic         ps2_clk;
    logic         ps2_data;
    logic         psel;
    logic         penable;
    logic         pwrite;
    keymap_addr_t paddr;
    keymap_data_t pwdata;
    keymap_data_t prdata;
    logic         pready;
    logic [7:0]   sp_row;
    col_t         sp_col;
    logic         master_reset;
    logic         user_reset;
    logic         user_nmi;
    logic         joy_up;
    logic         joy_down;
    logic         joy_left;
    logic         joy_right;
    logic         joy_fire;
    logic [4:0]   user_toggles;
    logic         frame_error;
    logic         overflow;

    // Expected keymap contents and Spectrum side state
    keymap_data_t km [2**`KEYMAP_ADDR_W];
    keymap_addr_t loaded [$];
    col_t         exp_matrix [8];
    keymap_data_t exp_ctrl;
    keymap_data_t exp_mod;
    int           errors;
    int           checks;
    int           cycles = 0;
    int           fe_count = 0;
    int           fe_before;
    int           assert_fails;

    speccy_keyboard speccy_keyboard_i (
        .clk          (clk),
        .rst          (rst),
        .ps2_clk      (ps2_clk),
        .ps2_data     (ps2_data),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .sp_row       (sp_row),
        .sp_col       (sp_col),
        .master_reset (master_reset),
        .user_reset   (user_reset),
        .user_nmi     (user_nmi),
        .joy_up       (joy_up),
        .joy_down     (joy_down),
        .joy_left     (joy_left),
        .joy_right    (joy_right),
        .joy_fire     (joy_fire),
        .user_toggles (user_toggles),
        .frame_error  (frame_error),
        .overflow     (overflow)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(negedge clk) begin
        if (frame_error) begin
            fe_count++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
            $display("Checks run: %0d, mismatches: %0d", checks, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    // ----------------------------------------
    // Drivers
    // ----------------------------------------
    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic ps2_bit(input logic b);
        ps2_data = b;
        idle_cycles(HALF_BIT);
        ps2_clk = 1'b0;
        idle_cycles(HALF_BIT);
        ps2_clk = 1'b1;
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic ps2_send(input scan_t data, input logic bad_parity);
        ps2_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            ps2_bit(data[i]);
        end
        ps2_bit(~^data ^ bad_parity);
        ps2_bit(1'b1);
        idle_cycles(HALF_BIT);
    endtask

    task automatic apb_access(input logic write, input keymap_addr_t addr,
                              input keymap_data_t wdata, output keymap_data_t rdata);
        int waited;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        idle_cycles(1);
        penable = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!pready && waited < 100) begin
            waited++;
            @(negedge clk);
        end
        rdata = prdata;
        assert (pready) else begin
            errors++;
            $display("APB access to address %h never got pready", addr);
        end
        idle_cycles(1);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    function automatic keymap_addr_t lookup_addr(logic [2:0] mods, logic ext, scan_t scan,
                                                 logic [1:0] entry);
        return {mods, ext, scan, entry};
    endfunction

    task automatic load_key(input logic [2:0] mods, input logic ext, input scan_t scan,
                            input keymap_data_t e0, input keymap_data_t e1,
                            input keymap_data_t e2, input keymap_data_t e3);
        keymap_data_t entries [4];
        keymap_data_t unused;
        keymap_addr_t addr;
        entries = '{e0, e1, e2, e3};
        for (int i = 0; i < 4; i++) begin
            addr = lookup_addr(mods, ext, scan, 2'(i));
            apb_access(1'b1, addr, entries[i], unused);
            km[addr] = entries[i];
            loaded.push_back(addr);
        end
    endtask

    // ----------------------------------------
    // Expected behavior
    // ----------------------------------------
    task automatic model_event(input logic rel, input logic ext, input scan_t scan);
        keymap_data_t e [4];
        for (int i = 0; i < 4; i++) begin
            e[i] = km[lookup_addr(exp_mod[7:5], ext, scan, 2'(i))];
        end
        // Matrix is active low, outputs active high
        for (int i = 0; i < 2; i++) begin
            if (rel) begin
                exp_matrix[e[i][7:5]] |= e[i][4:0];
            end else begin
                exp_matrix[e[i][7:5]] &= ~e[i][4:0];
            end
        end
        exp_ctrl = rel ? (exp_ctrl & ~e[2]) : (exp_ctrl | e[2]);
        exp_mod  = rel ? (exp_mod & ~e[3]) : (exp_mod | e[3]);
    endtask

    task automatic key_press(input logic ext, input scan_t scan);
        if (ext) begin
            ps2_send(8'hE0, 1'b0);
        end
        ps2_send(scan, 1'b0);
        model_event(1'b0, ext, scan);
    endtask

    task automatic key_release(input logic ext, input scan_t scan);
        if (ext) begin
            ps2_send(8'hE0, 1'b0);
        end
        ps2_send(8'hF0, 1'b0);
        ps2_send(scan, 1'b0);
        model_event(1'b1, ext, scan);
    endtask

    task automatic compare(input string name, input logic [7:0] expected,
                           input logic [7:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_readback();
        keymap_data_t got;
        foreach (loaded[i]) begin
            apb_access(1'b0, loaded[i], '0, got);
            compare($sformatf("apb_readback %h", loaded[i]), km[loaded[i]], got);
        end
    endtask

    task automatic check_outputs(input string name);
        col_t all_rows;
        all_rows = '1;
        for (int i = 0; i < 8; i++) begin
            sp_row = ~(8'd1 << i);
            @(negedge clk);
            compare($sformatf("%s row %0d", name, i), 8'(exp_matrix[i]), 8'(sp_col));
            all_rows &= exp_matrix[i];
            idle_cycles(1);
        end
        sp_row = 8'h00;
        @(negedge clk);
        compare({name, " all rows"}, 8'(all_rows), 8'(sp_col));
        idle_cycles(1);
        sp_row = 8'hFF;
        @(negedge clk);
        compare({name, " no row"}, 8'h1F, 8'(sp_col));
        compare({name, " control"}, exp_ctrl, {master_reset, user_reset, user_nmi,
                joy_up, joy_down, joy_left, joy_right, joy_fire});
        compare({name, " toggles"}, 8'(exp_mod[4:0]), 8'(user_toggles));
        idle_cycles(1);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        rst      = 1'b1;
        ps2_clk  = 1'b1;
        ps2_data = 1'b1;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        sp_row   = 8'hFF;
        errors   = 0;
        checks   = 0;
        for (int i = 0; i < 8; i++) begin
            exp_matrix[i] = '1;
        end
        exp_ctrl = '0;
        exp_mod  = '0;
        idle_cycles(10);
        rst = 1'b0;
        idle_cycles(5);
        check_outputs("reset");

        // A, '=' as symbol shift plus L, keypad 8, up arrow, left shift, F12
        load_key(3'd0, 1'b0, 8'h1C, 8'h21, 8'h00, 8'h00, 8'h00);
        load_key(3'd0, 1'b0, 8'h55, 8'hE2, 8'hC2, 8'h00, 8'h00);
        load_key(3'd0, 1'b0, 8'h75, 8'h84, 8'h00, 8'h00, 8'h00);
        load_key(3'd0, 1'b1, 8'h75, 8'h88, 8'h00, 8'h10, 8'h00);
        load_key(3'd0, 1'b0, 8'h12, 8'h01, 8'h00, 8'h00, 8'h20);
        load_key(3'd0, 1'b0, 8'h07, 8'h00, 8'h00, 8'hE1, 8'h12);
        // Table used while shift is held
        load_key(3'd1, 1'b0, 8'h1C, 8'hA1, 8'h00, 8'h00, 8'h00);
        load_key(3'd1, 1'b0, 8'h12, 8'h01, 8'h00, 8'h00, 8'h20);
        check_readback();

        key_press(1'b0, 8'h1C);
        check_outputs("press_a");
        key_release(1'b0, 8'h1C);
        check_outputs("release_a");
        key_press(1'b0, 8'h55);
        check_outputs("press_equals");
        key_release(1'b0, 8'h55);
        check_outputs("release_equals");

        key_press(1'b0, 8'h75);
        check_outputs("press_kp8");
        key_release(1'b0, 8'h75);
        key_press(1'b1, 8'h75);
        check_outputs("press_up");
        key_release(1'b1, 8'h75);
        check_outputs("release_up");

        key_press(1'b0, 8'h12);
        key_press(1'b0, 8'h1C);
        check_outputs("shift_a");
        key_release(1'b0, 8'h1C);
        key_release(1'b0, 8'h12);
        key_press(1'b0, 8'h1C);
        check_outputs("unshifted_a");
        key_release(1'b0, 8'h1C);

        key_press(1'b0, 8'h07);
        check_outputs("press_f12");
        key_release(1'b0, 8'h07);
        check_outputs("release_f12");

        fe_before = fe_count;
        ps2_send(8'h1C, 1'b1);
        compare("bad_parity frame_error", 8'(fe_before + 1), 8'(fe_count));
        check_outputs("bad_parity");
        key_press(1'b0, 8'h1C);
        check_outputs("after_error_a");
        key_release(1'b0, 8'h1C);
        check_outputs("after_error_release");

        assert_fails = speccy_keyboard_i.speccy_keyboard_assert_i.fail_count;
        $display("Checks run: %0d, mismatches: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+src
src/ps2_pkg.sv
src/speccy_pkg.sv
src/ps2_scan_rx.sv
src/scan_fifo.sv
src/keymap_translator.sv
src/speccy_keyboard.sv
verif/speccy_keyboard_assert.sv
verif/tb_speccy_keyboard.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_speccy_keyboard -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_speccy_keyboard +verilator+error+limit+100)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^All tests passed$"; then
    exit 0
fi
exit 1
